// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
    output logic Clk,
    output logic reset
);
    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // reset held for three rising edges, released on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;
    end

endmodule

// File: bench/ethTxMuxTb.sv
`timescale 1ns/1ps

module ethTxMuxTb;
    import ethTxPkg::*;

    // rough cycle counts of the tests that the watchdog scales by a margin
    localparam int testCycles = 100 + 300 + 200 + 300 + 30 * 120 + 300;
    localparam int marginFactor = 3;

    logic Clk;
    logic reset;
    logic linkUp;
    logic wrEn [numChannels];
    logic [7:0] wrData [numChannels];
    logic wrLast [numChannels];
    logic full [numChannels];
    logic txVal;
    logic txSof;
    logic txEof;
    logic [7:0] txData;

    // frames still owed on each channel in write order
    logic [7:0] expBytes [numChannels][$];
    int expLen [numChannels][$];
    logic [7:0] stageBuf [numChannels][queueDepth];
    int stageLen [numChannels];
    logic [7:0] rxBuf [$];
    int arrivals [$];
    bit inFrame;
    bit linkDown;
    int expectedCount;
    int receivedCount;
    int seed;
    logic [7:0] nextTag;

    clockGen clocks (.Clk(Clk), .reset(reset));

    ethTxMux uut (.Clk(Clk), .reset(reset), .linkUp(linkUp),
        .wrEn0(wrEn[0]), .wrData0(wrData[0]), .wrLast0(wrLast[0]),
        .wrEn1(wrEn[1]), .wrData1(wrData[1]), .wrLast1(wrLast[1]),
        .wrEn2(wrEn[2]), .wrData2(wrData[2]), .wrLast2(wrLast[2]),
        .wrEn3(wrEn[3]), .wrData3(wrData[3]), .wrLast3(wrLast[3]),
        .full0(full[0]), .full1(full[1]), .full2(full[2]), .full3(full[3]),
        .txVal(txVal), .txSof(txSof), .txEof(txEof), .txData(txData));

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            reportFailure($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compareFcs(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            reportFailure($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            reportFailure($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // bit-serial crc-32 over the head frame of a channel and inverted at the end
    function automatic logic [31:0] headFcs(input int ch);
        logic [31:0] r;
        logic fb;
        r = 32'hFFFF_FFFF;
        for (int i = 0; i < expLen[ch][0]; i++)
        begin
            for (int b = 0; b < 8; b++)
            begin
                fb = r[0] ^ expBytes[ch][i][b];
                r = r >> 1;
                if (fb)
                begin
                    r = r ^ 32'hEDB8_8320;
                end
            end
        end
        return ~r;
    endfunction

    // the first payload byte is a tag that matches a frame to its channel
    task automatic checkFrame();
        int n;
        int ch;
        logic [31:0] got;
        n = rxBuf.size();
        ch = -1;
        if (n < 5)
        begin
            reportFailure("received frame is shorter than its FCS plus one byte");
        end
        for (int c = 0; c < numChannels; c++)
        begin
            if (ch < 0 && expLen[c].size() > 0 && expBytes[c][0] == rxBuf[0])
            begin
                ch = c;
            end
        end
        if (ch < 0)
        begin
            reportFailure("received frame matches no frame at the head of any channel");
        end
        if (n - 4 != expLen[ch][0])
        begin
            reportFailure($sformatf("frame of channel %0d has %0d payload bytes, expected %0d",
                ch, n - 4, expLen[ch][0]));
        end
        for (int i = 0; i < n - 4; i++)
        begin
            compareByte("txData", rxBuf[i], expBytes[ch][i]);
        end
        got = {rxBuf[n-1], rxBuf[n-2], rxBuf[n-3], rxBuf[n-4]};
        compareFcs("txData fcs", got, headFcs(ch));
        for (int i = 0; i < n - 4; i++)
        begin
            void'(expBytes[ch].pop_front());
        end
        void'(expLen[ch].pop_front());
        arrivals.push_back(ch);
        receivedCount++;
    endtask

    // receiver samples the outputs at the falling edge where they are stable
    always @(negedge Clk)
    begin
        if (!reset && txVal)
        begin
            if (linkDown)
            begin
                reportFailure("txVal was raised while the link was down");
            end
            if (txSof)
            begin
                if (inFrame)
                begin
                    reportFailure("a new frame started before the previous one ended");
                end
                inFrame = 1'b1;
                rxBuf.delete();
            end
            else if (!inFrame)
            begin
                reportFailure("txVal was raised outside a frame");
            end
            rxBuf.push_back(txData);
            if (txEof)
            begin
                inFrame = 1'b0;
                checkFrame();
            end
        end
    end

    task automatic stageFrame(input int ch, input int len, input bit expected);
        stageLen[ch] = len;
        stageBuf[ch][0] = nextTag;
        nextTag = nextTag + 8'd1;
        for (int i = 1; i < len; i++)
        begin
            stageBuf[ch][i] = 8'($random(seed));
        end
        if (expected)
        begin
            for (int i = 0; i < len; i++)
            begin
                expBytes[ch].push_back(stageBuf[ch][i]);
            end
            expLen[ch].push_back(len);
            expectedCount++;
        end
    endtask

    // writes the staged frames of all masked channels side by side
    task automatic writeFrames(input logic [3:0] mask);
        int maxLen;
        maxLen = 0;
        for (int c = 0; c < numChannels; c++)
        begin
            if (mask[c] && stageLen[c] > maxLen)
            begin
                maxLen = stageLen[c];
            end
        end
        for (int i = 0; i < maxLen; i++)
        begin
            @(negedge Clk);
            for (int c = 0; c < numChannels; c++)
            begin
                wrEn[c] = mask[c] && i < stageLen[c];
                wrData[c] = (i < stageLen[c]) ? stageBuf[c][i] : 8'h00;
                wrLast[c] = mask[c] && i == stageLen[c] - 1;
            end
        end
        @(negedge Clk);
        for (int c = 0; c < numChannels; c++)
        begin
            wrEn[c] = 1'b0;
            wrLast[c] = 1'b0;
        end
    endtask

    task automatic waitAllReceived();
        while (receivedCount < expectedCount)
        begin
            @(negedge Clk);
        end
        // let the scheduler settle back in IDLE
        repeat (10) @(negedge Clk);
    endtask

    task automatic checkOrder(input int first, input int second, input int third, input int fourth);
        int want [4];
        want = '{first, second, third, fourth};
        for (int i = 0; i < arrivals.size(); i++)
        begin
            if (arrivals[i] != want[i])
            begin
                reportFailure($sformatf("frame %0d came from channel %0d, expected channel %0d",
                    i, arrivals[i], want[i]));
            end
        end
    endtask

    task automatic singleFrame();
        stageFrame(2, 20, 1'b1);
        writeFrames(4'b0100);
        waitAllReceived();
    endtask

    task automatic roundRobin();
        arrivals.delete();
        for (int c = 0; c < numChannels; c++)
        begin
            stageFrame(c, 12, 1'b1);
        end
        writeFrames(4'b1111);
        waitAllReceived();
        if (arrivals.size() != 4)
        begin
            reportFailure("round robin test did not receive four frames");
        end
        checkOrder(0, 1, 2, 3);
    endtask

    // channel 2 waits while channel 1 still has a second frame queued
    task automatic heldChannel();
        arrivals.delete();
        stageFrame(1, 8, 1'b1);
        stageFrame(2, 8, 1'b1);
        writeFrames(4'b0110);
        stageFrame(1, 8, 1'b1);
        writeFrames(4'b0010);
        waitAllReceived();
        if (arrivals.size() != 3)
        begin
            reportFailure("held channel test did not receive three frames");
        end
        checkOrder(1, 1, 2, 0);
    endtask

    task automatic linkDownDrain();
        @(negedge Clk);
        linkUp = 1'b0;
        linkDown = 1'b1;
        stageFrame(0, 16, 1'b0);
        stageFrame(3, 16, 1'b0);
        writeFrames(4'b1001);
        repeat (80) @(negedge Clk);
        linkDown = 1'b0;
        linkUp = 1'b1;
        stageFrame(2, 24, 1'b1);
        writeFrames(4'b0100);
        waitAllReceived();
    endtask

    task automatic randomTraffic();
        int ch;
        int len;
        repeat (30)
        begin
            ch = int'($unsigned($random(seed)) % 4);
            len = 1 + int'($unsigned($random(seed)) % 40);
            // keep the queue from overflowing
            while (expBytes[ch].size() + len > queueDepth)
            begin
                @(negedge Clk);
            end
            stageFrame(ch, len, 1'b1);
            writeFrames(4'(1 << ch));
        end
        waitAllReceived();
    endtask

    task automatic fullFlag();
        stageFrame(3, queueDepth, 1'b1);
        writeFrames(4'b1000);
        compareFlag("full3", full[3], 1'b1);
        for (int c = 0; c < 3; c++)
        begin
            compareFlag($sformatf("full%0d", c), full[c], 1'b0);
        end
        // extra byte must be dropped while the queue is full
        wrEn[3] = 1'b1;
        wrData[3] = 8'hEE;
        wrLast[3] = 1'b1;
        @(negedge Clk);
        wrEn[3] = 1'b0;
        wrLast[3] = 1'b0;
        waitAllReceived();
        compareFlag("full3", full[3], 1'b0);
    endtask

    initial
    begin
        #(testCycles * marginFactor * 10);
        reportFailure("watchdog timeout, the tests did not finish in time");
    end

    initial
    begin
        linkUp = 1'b1;
        for (int c = 0; c < numChannels; c++)
        begin
            wrEn[c] = 1'b0;
            wrData[c] = 8'h00;
            wrLast[c] = 1'b0;
            stageLen[c] = 0;
        end
        seed = 32'h451b_0938;
        nextTag = 8'h00;
        expectedCount = 0;
        receivedCount = 0;
        inFrame = 1'b0;
        linkDown = 1'b0;
        @(negedge Clk);
        while (reset)
        begin
            @(negedge Clk);
        end
        repeat (5) @(negedge Clk);
        singleFrame();
        roundRobin();
        heldChannel();
        linkDownDrain();
        randomTraffic();
        fullFlag();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: build.f
src/ethTxPkg.sv
src/txFrameQueue.sv
src/ethScheduler.sv
src/fcsAppender.sv
src/ethTxMux.sv
bench/clockGen.sv
bench/ethTxMuxTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the ethTxMux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module ethTxMuxTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: src/ethScheduler.sv
`timescale 1ns/1ps

module ethScheduler
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       linkUp,
    input  logic       valIn0,
    input  logic       sofIn0,
    input  logic       eofIn0,
    input  logic       reqIn0,
    input  logic [7:0] dataIn0,
    input  logic       valIn1,
    input  logic       sofIn1,
    input  logic       eofIn1,
    input  logic       reqIn1,
    input  logic [7:0] dataIn1,
    input  logic       valIn2,
    input  logic       sofIn2,
    input  logic       eofIn2,
    input  logic       reqIn2,
    input  logic [7:0] dataIn2,
    input  logic       valIn3,
    input  logic       sofIn3,
    input  logic       eofIn3,
    input  logic       reqIn3,
    input  logic [7:0] dataIn3,
    output logic [ethTxPkg::numChannels-1:0] reqConfirm,
    output logic       valOut,
    output logic       sofOut,
    output logic       eofOut,
    output logic [7:0] dataOut
);
    import ethTxPkg::*;

    logic [2:0] state;
    logic waitRequest;
    logic [numChannels-1:0] reqVec;
    logic [numChannels-1:0] selMask;
    logic selVal;
    logic selSof;
    logic selEof;
    logic [7:0] selData;

    assign reqVec = {reqIn3, reqIn2, reqIn1, reqIn0};

    // channel picked by the current state
    always_comb
    begin
        selMask = '0;
        selVal = 1'b0;
        selSof = 1'b0;
        selEof = 1'b0;
        selData = 8'h00;
        case (state)
            stZero:
            begin
                selMask = numChannels'(1) << 0;
                selVal = valIn0;
                selSof = sofIn0;
                selEof = eofIn0;
                selData = dataIn0;
            end
            stOne:
            begin
                selMask = numChannels'(1) << 1;
                selVal = valIn1;
                selSof = sofIn1;
                selEof = eofIn1;
                selData = dataIn1;
            end
            stTwo:
            begin
                selMask = numChannels'(1) << 2;
                selVal = valIn2;
                selSof = sofIn2;
                selEof = eofIn2;
                selData = dataIn2;
            end
            stThree:
            begin
                selMask = numChannels'(1) << 3;
                selVal = valIn3;
                selSof = sofIn3;
                selEof = eofIn3;
                selData = dataIn3;
            end
            default:
            begin
                selMask = '0;
            end
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            state <= stZero;
            waitRequest <= 1'b0;
            reqConfirm <= '0;
            valOut <= 1'b0;
            sofOut <= 1'b0;
            eofOut <= 1'b0;
        end
        else
        begin
            waitRequest <= |reqVec;
            if (state == stIdle)
            begin
                state <= waitRequest ? stZero : stIdle;
            end
            // hold while the selected channel still requests
            else if ((reqVec & selMask) == '0)
            begin
                state <= (state == stThree) ? stIdle : state + 3'd1;
            end
            reqConfirm <= reqVec & selMask;
            valOut <= selVal & linkUp;
            sofOut <= selSof;
            eofOut <= selEof;
        end
    end

    always_ff @(posedge Clk)
    begin
        dataOut <= selData;
    end

endmodule

// File: src/ethTxMux.sv
`timescale 1ns/1ps

module ethTxMux
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       linkUp,
    input  logic       wrEn0,
    input  logic [7:0] wrData0,
    input  logic       wrLast0,
    input  logic       wrEn1,
    input  logic [7:0] wrData1,
    input  logic       wrLast1,
    input  logic       wrEn2,
    input  logic [7:0] wrData2,
    input  logic       wrLast2,
    input  logic       wrEn3,
    input  logic [7:0] wrData3,
    input  logic       wrLast3,
    output logic       full0,
    output logic       full1,
    output logic       full2,
    output logic       full3,
    output logic       txVal,
    output logic       txSof,
    output logic       txEof,
    output logic [7:0] txData
);
    import ethTxPkg::*;

    logic [numChannels-1:0] reqConfirm;
    logic req0, val0, sof0, eof0;
    logic req1, val1, sof1, eof1;
    logic req2, val2, sof2, eof2;
    logic req3, val3, sof3, eof3;
    logic [7:0] data0, data1, data2, data3;
    logic schedVal, schedSof, schedEof;
    logic [7:0] schedData;

    txFrameQueue queue0 (.Clk(Clk), .reset(reset), .wrEn(wrEn0), .wrData(wrData0),
        .wrLast(wrLast0), .reqConfirm(reqConfirm[0]), .full(full0), .req(req0),
        .val(val0), .sof(sof0), .eof(eof0), .data(data0));

    txFrameQueue queue1 (.Clk(Clk), .reset(reset), .wrEn(wrEn1), .wrData(wrData1),
        .wrLast(wrLast1), .reqConfirm(reqConfirm[1]), .full(full1), .req(req1),
        .val(val1), .sof(sof1), .eof(eof1), .data(data1));

    txFrameQueue queue2 (.Clk(Clk), .reset(reset), .wrEn(wrEn2), .wrData(wrData2),
        .wrLast(wrLast2), .reqConfirm(reqConfirm[2]), .full(full2), .req(req2),
        .val(val2), .sof(sof2), .eof(eof2), .data(data2));

    txFrameQueue queue3 (.Clk(Clk), .reset(reset), .wrEn(wrEn3), .wrData(wrData3),
        .wrLast(wrLast3), .reqConfirm(reqConfirm[3]), .full(full3), .req(req3),
        .val(val3), .sof(sof3), .eof(eof3), .data(data3));

    ethScheduler scheduler (.Clk(Clk), .reset(reset), .linkUp(linkUp),
        .valIn0(val0), .sofIn0(sof0), .eofIn0(eof0), .reqIn0(req0), .dataIn0(data0),
        .valIn1(val1), .sofIn1(sof1), .eofIn1(eof1), .reqIn1(req1), .dataIn1(data1),
        .valIn2(val2), .sofIn2(sof2), .eofIn2(eof2), .reqIn2(req2), .dataIn2(data2),
        .valIn3(val3), .sofIn3(sof3), .eofIn3(eof3), .reqIn3(req3), .dataIn3(data3),
        .reqConfirm(reqConfirm), .valOut(schedVal), .sofOut(schedSof),
        .eofOut(schedEof), .dataOut(schedData));

    fcsAppender appender (.Clk(Clk), .reset(reset), .valIn(schedVal), .sofIn(schedSof),
        .eofIn(schedEof), .dataIn(schedData), .txVal(txVal), .txSof(txSof),
        .txEof(txEof), .txData(txData));

endmodule

// File: src/ethTxPkg.sv
package ethTxPkg;

    // channel and queue sizing
    localparam int numChannels = 4;
    localparam int queueDepth = 64;
    localparam int queueAddrBits = 6;

    // ethernet crc-32, processed lsb first
    localparam logic [31:0] crcInit = 32'hFFFF_FFFF;
    localparam logic [31:0] crcPoly = 32'hEDB8_8320;
    localparam logic [31:0] crcXorOut = 32'hFFFF_FFFF;

    // scheduler states in round-robin order
    localparam logic [2:0] stIdle = 3'd0;
    localparam logic [2:0] stZero = 3'd1;
    localparam logic [2:0] stOne = 3'd2;
    localparam logic [2:0] stTwo = 3'd3;
    localparam logic [2:0] stThree = 3'd4;

    // queue read side states
    localparam logic [1:0] qIdle = 2'd0;
    localparam logic [1:0] qStart = 2'd1;
    localparam logic [1:0] qStream = 2'd2;
    localparam logic [1:0] qHold = 2'd3;

    // quiet cycles after a frame so the fcs bytes fit before the next sof
    localparam logic [1:0] holdCycles = 2'd3;

endpackage

// File: src/fcsAppender.sv
`timescale 1ns/1ps

module fcsAppender
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       valIn,
    input  logic       sofIn,
    input  logic       eofIn,
    input  logic [7:0] dataIn,
    output logic       txVal,
    output logic       txSof,
    output logic       txEof,
    output logic [7:0] txData
);
    import ethTxPkg::*;

    logic [31:0] crc;
    logic [31:0] crcNext;
    logic fcsBusy;
    logic [1:0] fcsCnt;

    // reflected bytewise crc-32 update
    function automatic logic [31:0] crcByte(input logic [31:0] crcIn, input logic [7:0] b);
        logic [31:0] c;
        c = crcIn ^ {24'h000000, b};
        for (int i = 0; i < 8; i++)
        begin
            c = c[0] ? ((c >> 1) ^ crcPoly) : (c >> 1);
        end
        return c;
    endfunction

    assign crcNext = crcByte(sofIn ? crcInit : crc, dataIn);

    // after eof the same register shifts the fcs out, low byte first
    always_ff @(posedge Clk)
    begin
        if (fcsBusy)
        begin
            crc <= {8'h00, crc[31:8]};
        end
        else if (valIn)
        begin
            crc <= crcNext;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            txVal <= 1'b0;
            txSof <= 1'b0;
            txEof <= 1'b0;
            fcsBusy <= 1'b0;
            fcsCnt <= '0;
        end
        else if (fcsBusy)
        begin
            txVal <= 1'b1;
            txSof <= 1'b0;
            txEof <= fcsCnt == 2'd3;
            fcsCnt <= fcsCnt + 1'b1;
            if (fcsCnt == 2'd3)
            begin
                fcsBusy <= 1'b0;
            end
        end
        else
        begin
            txVal <= valIn;
            txSof <= valIn && sofIn;
            // frame end is withheld, the last fcs byte carries it
            txEof <= 1'b0;
            if (valIn && eofIn)
            begin
                fcsBusy <= 1'b1;
                fcsCnt <= '0;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (fcsBusy)
        begin
            txData <= crc[7:0] ^ crcXorOut[8*fcsCnt +: 8];
        end
        else
        begin
            txData <= dataIn;
        end
    end

endmodule

// File: src/txFrameQueue.sv
`timescale 1ns/1ps

module txFrameQueue
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       wrEn,
    input  logic [7:0] wrData,
    input  logic       wrLast,
    input  logic       reqConfirm,
    output logic       full,
    output logic       req,
    output logic       val,
    output logic       sof,
    output logic       eof,
    output logic [7:0] data
);
    import ethTxPkg::*;

    // each entry holds the byte and its last-byte flag in bit 8
    logic [8:0] mem [queueDepth];
    logic [queueAddrBits:0] wrPtr;
    logic [queueAddrBits:0] rdPtr;
    logic [queueAddrBits:0] frameCount;
    logic [1:0] readState;
    logic [1:0] holdCnt;
    logic [8:0] rdWord;
    logic wrAccept;
    logic frameIn;
    logic frameOut;
    logic reading;

    assign full = (wrPtr - rdPtr) == (queueAddrBits + 1)'(queueDepth);
    assign wrAccept = wrEn && !full;
    assign frameIn = wrAccept && wrLast;
    assign rdWord = mem[rdPtr[queueAddrBits-1:0]];
    assign reading = (readState == qStart) || (readState == qStream);
    assign frameOut = reading && rdWord[8];

    always_ff @(posedge Clk)
    begin
        if (wrAccept)
        begin
            mem[wrPtr[queueAddrBits-1:0]] <= {wrLast, wrData};
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            frameCount <= '0;
            req <= 1'b0;
        end
        else
        begin
            if (wrAccept)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (reading)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({frameIn, frameOut})
                2'b10: frameCount <= frameCount + 1'b1;
                2'b01: frameCount <= frameCount - 1'b1;
                default: frameCount <= frameCount;
            endcase
            // lags the frame count by a cycle, so it falls the cycle after eof
            req <= frameCount != '0;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            readState <= qIdle;
            holdCnt <= '0;
            val <= 1'b0;
            sof <= 1'b0;
            eof <= 1'b0;
        end
        else
        begin
            val <= reading;
            sof <= readState == qStart;
            eof <= frameOut;
            case (readState)
                qIdle:
                begin
                    if (reqConfirm && frameCount != '0)
                    begin
                        readState <= qStart;
                    end
                end
                qStart, qStream:
                begin
                    if (rdWord[8])
                    begin
                        readState <= qHold;
                        holdCnt <= holdCycles;
                    end
                    else
                    begin
                        readState <= qStream;
                    end
                end
                qHold:
                begin
                    if (holdCnt != '0)
                    begin
                        holdCnt <= holdCnt - 1'b1;
                    end
                    // confirm still high means the scheduler kept this channel
                    else if (reqConfirm && frameCount != '0)
                    begin
                        readState <= qStart;
                    end
                    else
                    begin
                        readState <= qIdle;
                    end
                end
                default: readState <= qIdle;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        data <= rdWord[7:0];
    end

endmodule
